// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= exmem_tb
FILELIST  ?= sources.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/exmem_props.sv ====
// exmem_props: concurrent checks on writeback and exception outputs, bound into exmem_top
`timescale 1ns/1ps
`default_nettype none

module exmem_props import exmem_pkg::*; (
    input wire     clk,
    input wire     arst_n_i,
    input wire     wb_allowin_i,
    input wb_pkt_t wb1_o,
    input wb_pkt_t wb2_o,
    input excp_t   excp_o
);

    // outputs idle while reset is held
    a_reset_idle: assert property (@(posedge clk)
        !arst_n_i |-> !wb1_o.valid && !wb2_o.valid && !excp_o.valid)
        else $error("writeback or exception active during reset");

    // a stalled writeback keeps its contents
    a_wb_hold: assert property (@(posedge clk) disable iff (!arst_n_i)
        (!wb_allowin_i && (wb1_o.valid || wb2_o.valid)) |=> $stable(wb1_o) && $stable(wb2_o))
        else $error("writeback changed while stalled");

    // flush empties the EX/MEM register, so no second report follows
    a_excp_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
        excp_o.valid |=> !excp_o.valid)
        else $error("exception report longer than one cycle");

    // lane 1 fault kills both writebacks of that packet
    a_lane1_kill: assert property (@(posedge clk) disable iff (!arst_n_i)
        (excp_o.valid && !excp_o.lane) |-> !wb1_o.valid && !wb2_o.valid)
        else $error("writeback after a lane 1 fault");

endmodule

bind exmem_top exmem_props exmem_props_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .wb_allowin_i (wb_allowin_i),
    .wb1_o        (wb1_o),
    .wb2_o        (wb2_o),
    .excp_o       (excp_o)
);

`default_nettype wire

// ==== sim/exmem_tb.sv ====
// exmem_tb: clock, reset, LCG traffic, queue reference model, timeouts and final report
`timescale 1ns/1ps
`default_nettype none

module exmem_tb;
    import exmem_pkg::*;

    logic       clk;
    logic       arst_n_i;
    logic       lane1_valid_i;
    logic       lane2_valid_i;
    issue_pkt_t lane1_pkt_i;
    issue_pkt_t lane2_pkt_i;
    logic       in_allowin_o;
    logic       wb_allowin_i;
    wb_pkt_t    wb1_o;
    wb_pkt_t    wb2_o;
    excp_t      excp_o;

    // reference state
    logic [31:0]     lcg_state = 32'h239e;
    logic [XLEN-1:0] ref_mem [64];
    logic [REG_AW-1:0] exp_rd [$];
    logic [XLEN-1:0] exp_data [$];
    int              exp_lane [$];
    int              exp_cyc [$];
    logic            exp_excp_pend;
    logic            exp_excp_lane;
    logic [XLEN-1:0] exp_excp_addr;
    logic            excp_seen;
    logic            timing_on;
    logic            stall_mode;
    int              cyc;
    int              checks;
    int              errors;

    exmem_top #(.MEM_AW(MEM_WORDS_LOG2)) exmem_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // build one lane; word index and misalignment only matter for load/store
    function automatic issue_pkt_t make_lane(input op_e op, input int widx, input int mis);
        issue_pkt_t p;
        logic [XLEN-1:0] target;
        logic [31:0]     rnd;
        target   = widx * 4 + mis;
        p.op     = op;
        rnd      = lcg_next();
        p.rd     = rnd[11:7];
        p.src_b  = lcg_next();
        rnd      = lcg_next();
        p.imm    = {26'd0, rnd[31:28], 2'b00};
        p.src_a  = (op == OP_LOAD || op == OP_STORE) ? target - p.imm : lcg_next();
        return p;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("error %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("checks %0d errors %0d", checks, errors + 1);
        $display("SOME TESTS FAILED");
        $finish;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model for one lane in program order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // returns 1 when the lane faults
    function automatic logic model_lane(input issue_pkt_t p, input int lane);
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] val;
        addr = p.src_a + p.imm;
        if ((p.op == OP_LOAD || p.op == OP_STORE) && addr[1:0] != 2'b00) begin
            exp_excp_pend = 1'b1;
            exp_excp_lane = (lane == 2);
            exp_excp_addr = addr;
            return 1'b1;
        end
        case (p.op)
            OP_ADD:  val = p.src_a + p.src_b;
            OP_SUB:  val = p.src_a - p.src_b;
            OP_AND:  val = p.src_a & p.src_b;
            OP_OR:   val = p.src_a | p.src_b;
            OP_XOR:  val = p.src_a ^ p.src_b;
            OP_SLT:  val = ($signed(p.src_a) < $signed(p.src_b)) ? 1 : 0;
            OP_LOAD: val = ref_mem[addr[7:2]];
            default: val = '0;
        endcase
        if (p.op == OP_STORE) begin
            ref_mem[addr[7:2]] = p.src_b;
        end else begin
            exp_rd.push_back(p.rd);
            exp_data.push_back(val);
            exp_lane.push_back(lane);
            exp_cyc.push_back(cyc);
        end
        return 1'b0;
    endfunction

    // compare one writeback port against the head of the queue
    task automatic check_wb(input wb_pkt_t wb, input int lane);
        if (exp_rd.size() == 0) begin
            abort_run("writeback appeared with nothing expected");
        end else begin
            check_val("wb_lane", lane, exp_lane.pop_front());
            check_val("wb_rd", 32'(wb.rd), 32'(exp_rd.pop_front()));
            check_val("wb_data", wb.data, exp_data.pop_front());
            // EX/MEM captures at the accepting edge and the writeback register one edge later
            if (timing_on) begin
                check_val("wb_cycle", cyc, exp_cyc[0] + 2);
            end
            void'(exp_cyc.pop_front());
        end
    endtask

    // drive at the falling edge, then check what the next rising edge will consume
    task automatic run_cycle(input logic v1, input issue_pkt_t p1, input logic v2,
                             input issue_pkt_t p2, output logic accepted);
        logic        f1;
        logic [31:0] rnd;
        @(negedge clk);
        cyc++;
        rnd           = lcg_next();
        wb_allowin_i  = !(stall_mode && (rnd[9:8] == 2'b00));
        lane1_valid_i = v1;
        lane2_valid_i = v2;
        lane1_pkt_i   = p1;
        lane2_pkt_i   = p2;
        #1;
        if (wb_allowin_i && wb1_o.valid) check_wb(wb1_o, 1);
        if (wb_allowin_i && wb2_o.valid) check_wb(wb2_o, 2);
        if (excp_o.valid) begin
            check_val("excp_o.valid", 32'(excp_o.valid), 32'(exp_excp_pend));
            check_val("excp_o.lane", 32'(excp_o.lane), 32'(exp_excp_lane));
            check_val("excp_o.bad_addr", excp_o.bad_addr, exp_excp_addr);
            exp_excp_pend = 1'b0;
            excp_seen     = 1'b1;
        end
        // an issue slot is taken whenever the DUT allows in, even with both lanes empty
        accepted = in_allowin_o;
        if (accepted) begin
            f1 = v1 ? model_lane(p1, 1) : 1'b0;
            // lane 1 fault kills lane 2 as well
            if (v2 && !f1) void'(model_lane(p2, 2));
        end
    endtask

    task automatic send_packet(input logic v1, input issue_pkt_t p1,
                               input logic v2, input issue_pkt_t p2);
        logic acc;
        int   n;
        acc = 1'b0;
        n   = 0;
        while (!acc && n < 50) begin
            run_cycle(v1, p1, v2, p2, acc);
            n++;
        end
        if (!acc) begin
            abort_run("issue was not accepted within 50 cycles");
        end
    endtask

    task automatic idle_until_excp();
        logic acc;
        int   n;
        n = 0;
        excp_seen = 1'b0;
        while (!excp_seen && n < 20) begin
            run_cycle(1'b0, '0, 1'b0, '0, acc);
            n++;
        end
        if (!excp_seen) begin
            abort_run("exception report did not arrive within 20 cycles");
        end
    endtask

    task automatic drain();
        logic acc;
        int   n;
        n = 0;
        while ((exp_rd.size() != 0 || exp_excp_pend) && n < 200) begin
            run_cycle(1'b0, '0, 1'b0, '0, acc);
            n++;
        end
        if (exp_rd.size() != 0 || exp_excp_pend) begin
            abort_run("pipeline did not drain within 200 cycles");
        end
    endtask

    // random packets keep memory ops aligned inside the 16-word window
    task automatic send_random();
        logic [31:0] r1;
        logic [31:0] r2;
        issue_pkt_t  p1;
        issue_pkt_t  p2;
        r1 = lcg_next();
        r2 = lcg_next();
        p1 = make_lane(op_e'(r1[31:29]), int'(r1[27:24]), 0);
        p2 = make_lane(op_e'(r2[31:29]), int'(r2[27:24]), 0);
        send_packet(r1[4], p1, r2[4], p2);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        arst_n_i      = 1'b0;
        lane1_valid_i = 1'b0;
        lane2_valid_i = 1'b0;
        lane1_pkt_i   = '0;
        lane2_pkt_i   = '0;
        wb_allowin_i  = 1'b1;
        exp_excp_pend = 1'b0;
        excp_seen     = 1'b0;
        timing_on     = 1'b1;
        stall_mode    = 1'b0;
        cyc           = 0;
        checks        = 0;
        errors        = 0;
        repeat (4) @(negedge clk);
        arst_n_i = 1'b1;
        #1;
        // idle after reset
        check_val("in_allowin_o", 32'(in_allowin_o), 1);
        check_val("wb1_o.valid", 32'(wb1_o.valid), 0);
        check_val("wb2_o.valid", 32'(wb2_o.valid), 0);
        check_val("excp_o.valid", 32'(excp_o.valid), 0);
        // fill the window so every later load has a known word
        for (int w = 0; w < 16; w += 2) begin
            send_packet(1, make_lane(OP_STORE, w, 0), 1, make_lane(OP_STORE, w + 1, 0));
        end
        for (int i = 0; i < 40; i++) begin
            send_packet(1, make_lane(op_e'(3'(lcg_next() % 6)), 0, 0),
                        1, make_lane(op_e'(3'(lcg_next() % 6)), 0, 0));
        end
        // lane 2 load sees lane 1 store in the same packet
        send_packet(1, make_lane(OP_STORE, 5, 0), 1, make_lane(OP_LOAD, 5, 0));
        send_packet(1, make_lane(OP_LOAD, 5, 0), 1, make_lane(OP_LOAD, 6, 0));
        drain();
        timing_on  = 1'b0;
        stall_mode = 1'b1;
        for (int i = 0; i < 200; i++) send_random();
        drain();
        stall_mode = 1'b0;
        // misaligned lane 1 store takes lane 2 down with it
        send_packet(1, make_lane(OP_STORE, 9, 2), 1, make_lane(OP_ADD, 0, 0));
        idle_until_excp();
        send_packet(1, make_lane(OP_LOAD, 9, 0), 0, '0);
        // misaligned lane 2 load while lane 1 survives
        send_packet(1, make_lane(OP_XOR, 0, 0), 1, make_lane(OP_LOAD, 3, 1));
        idle_until_excp();
        stall_mode = 1'b1;
        for (int i = 0; i < 30; i++) send_random();
        drain();
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/ex_mem_reg.sv ====
// ex_mem_reg: EX-to-MEM pipeline register with per-lane valids, hold and flush clear
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg import exmem_pkg::*; (
    input  wire              clk,
    input  wire              arst_n_i,

    // from execute
    input  wire              lane1_pre_valid_i,
    input  wire              lane2_pre_valid_i,
    // index 0 is lane 1
    input  ex_pkt_t [1:0]    pre_bus_i,

    // from memory stage
    input  wire              excep_flush_i,
    input  wire              now_allowin_i,

    // to memory stage
    output logic             lane1_now_valid_o,
    output logic             lane2_now_valid_o,
    output ex_pkt_t [1:0]    to_mem_o
);

    logic any_pre_valid;

    assign any_pre_valid = lane1_pre_valid_i | lane2_pre_valid_i;

    // lane valids
    // flush wins over a load in the same cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            lane1_now_valid_o <= 1'b0;
            lane2_now_valid_o <= 1'b0;
        end else if (excep_flush_i) begin
            lane1_now_valid_o <= 1'b0;
            lane2_now_valid_o <= 1'b0;
        end else if (now_allowin_i) begin
            lane1_now_valid_o <= lane1_pre_valid_i;
            lane2_now_valid_o <= lane2_pre_valid_i;
        end
    end

    // payload, only captured when something real arrives
    always_ff @(posedge clk) begin
        if (now_allowin_i && any_pre_valid) begin
            to_mem_o <= pre_bus_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/ex_stage.sv ====
// ex_stage: two-lane ALU and address generation, combinational, with allowin pass-back
`timescale 1ns/1ps
`default_nettype none

module ex_stage import exmem_pkg::*; (
    // issue side
    input  wire        lane1_valid_i,
    input  wire        lane2_valid_i,
    input  issue_pkt_t lane1_pkt_i,
    input  issue_pkt_t lane2_pkt_i,
    output logic       in_allowin_o,

    // towards the EX/MEM register
    input  wire        now_allowin_i,
    output logic       lane1_valid_o,
    output logic       lane2_valid_o,
    output ex_pkt_t    lane1_ex_o,
    output ex_pkt_t    lane2_ex_o
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // per-lane execute
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // same datapath for both lanes
    function automatic ex_pkt_t execute(input issue_pkt_t pkt);
        ex_pkt_t res;
        res.op         = pkt.op;
        res.rd         = pkt.rd;
        // store data always comes from src_b
        res.store_data = pkt.src_b;
        unique case (pkt.op)
            OP_ADD:   res.result = pkt.src_a + pkt.src_b;
            OP_SUB:   res.result = pkt.src_a - pkt.src_b;
            OP_AND:   res.result = pkt.src_a & pkt.src_b;
            OP_OR:    res.result = pkt.src_a | pkt.src_b;
            OP_XOR:   res.result = pkt.src_a ^ pkt.src_b;
            // signed compare, result is 0 or 1
            OP_SLT: begin
                res.result = {{(XLEN-1){1'b0}},
                              ($signed(pkt.src_a) < $signed(pkt.src_b))};
            end
            // effective address for memory ops
            OP_LOAD,
            OP_STORE: res.result = pkt.src_a + pkt.imm;
            default:  res.result = '0;
        endcase
        return res;
    endfunction

    always_comb begin
        lane1_ex_o = execute(lane1_pkt_i);
        lane2_ex_o = execute(lane2_pkt_i);
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // no state here, so the stage is ready whenever downstream is
    assign in_allowin_o  = now_allowin_i;
    // lanes travel together with their issue valids
    assign lane1_valid_o = lane1_valid_i;
    assign lane2_valid_o = lane2_valid_i;

endmodule

`default_nettype wire

// ==== source/exmem_pkg.sv ====
// shared widths, opcode enum and packet structs for the execute/memory pipeline
`default_nettype none

package exmem_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // data word width
    localparam int XLEN = 32;
    // default data memory depth in address bits
    localparam int MEM_WORDS_LOG2 = 6;
    // destination register index width
    localparam int REG_AW = 5;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcodes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_SLT   = 3'd5,
        // memory ops use src_a + imm as the address
        OP_LOAD  = 3'd6,
        OP_STORE = 3'd7
    } op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // packets
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one lane as it arrives from issue
    typedef struct packed {
        op_e               op;
        logic [XLEN-1:0]   src_a;
        // also the store data
        logic [XLEN-1:0]   src_b;
        logic [XLEN-1:0]   imm;
        logic [REG_AW-1:0] rd;
    } issue_pkt_t;

    // one lane after execute
    typedef struct packed {
        op_e               op;
        // alu value, or effective address for load/store
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   store_data;
        logic [REG_AW-1:0] rd;
    } ex_pkt_t;

    // registered writeback of one lane
    typedef struct packed {
        logic              valid;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
    } wb_pkt_t;

    // misaligned access report
    typedef struct packed {
        logic            valid;
        // 0 for lane 1, 1 for lane 2
        logic            lane;
        logic [XLEN-1:0] bad_addr;
    } excp_t;

endpackage

`default_nettype wire

// ==== source/exmem_top.sv ====
// exmem_top: execute stage, EX/MEM register and memory stage wired together
`timescale 1ns/1ps
`default_nettype none

module exmem_top import exmem_pkg::*; #(
    parameter int MEM_AW = MEM_WORDS_LOG2
) (
    input  wire        clk,
    input  wire        arst_n_i,

    // issue
    input  wire        lane1_valid_i,
    input  wire        lane2_valid_i,
    input  issue_pkt_t lane1_pkt_i,
    input  issue_pkt_t lane2_pkt_i,
    output logic       in_allowin_o,

    // writeback
    input  wire        wb_allowin_i,
    output wb_pkt_t    wb1_o,
    output wb_pkt_t    wb2_o,
    output excp_t      excp_o
);

    // execute to register
    logic          ex_lane1_valid;
    logic          ex_lane2_valid;
    ex_pkt_t [1:0] ex_bus;
    logic          exreg_allowin;

    // register to memory
    logic          mem_lane1_valid;
    logic          mem_lane2_valid;
    ex_pkt_t [1:0] mem_bus;
    logic          mem_allowin;
    logic          excep_flush;

    ex_stage ex_stage_i (
        .lane1_valid_i (lane1_valid_i),
        .lane2_valid_i (lane2_valid_i),
        .lane1_pkt_i   (lane1_pkt_i),
        .lane2_pkt_i   (lane2_pkt_i),
        .in_allowin_o  (in_allowin_o),
        .now_allowin_i (exreg_allowin),
        .lane1_valid_o (ex_lane1_valid),
        .lane2_valid_o (ex_lane2_valid),
        .lane1_ex_o    (ex_bus[0]),
        .lane2_ex_o    (ex_bus[1])
    );

    // register has no combinational logic of its own, allowin comes from MEM
    assign exreg_allowin = mem_allowin;

    ex_mem_reg ex_mem_reg_i (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .lane1_pre_valid_i (ex_lane1_valid),
        .lane2_pre_valid_i (ex_lane2_valid),
        .pre_bus_i         (ex_bus),
        .excep_flush_i     (excep_flush),
        .now_allowin_i     (mem_allowin),
        .lane1_now_valid_o (mem_lane1_valid),
        .lane2_now_valid_o (mem_lane2_valid),
        .to_mem_o          (mem_bus)
    );

    mem_stage #(
        .MEM_AW (MEM_AW)
    ) mem_stage_i (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .lane1_valid_i (mem_lane1_valid),
        .lane2_valid_i (mem_lane2_valid),
        .mem_bus_i     (mem_bus),
        .wb_allowin_i  (wb_allowin_i),
        .mem_allowin_o (mem_allowin),
        .excep_flush_o (excep_flush),
        .wb1_o         (wb1_o),
        .wb2_o         (wb2_o),
        .excp_o        (excp_o)
    );

endmodule

`default_nettype wire

// ==== source/mem_stage.sv ====
// mem_stage: data memory, alignment check, flush, store forwarding and writeback register
`timescale 1ns/1ps
`default_nettype none

module mem_stage import exmem_pkg::*; #(
    parameter int MEM_AW = MEM_WORDS_LOG2
) (
    input  wire              clk,
    input  wire              arst_n_i,

    // from the EX/MEM register
    input  wire              lane1_valid_i,
    input  wire              lane2_valid_i,
    input  ex_pkt_t [1:0]    mem_bus_i,

    // backward control
    input  wire              wb_allowin_i,
    output logic             mem_allowin_o,
    output logic             excep_flush_o,

    // registered outputs
    output wb_pkt_t          wb1_o,
    output wb_pkt_t          wb2_o,
    output excp_t            excp_o
);

    // data memory, no reset on contents
    logic [XLEN-1:0] mem_q [2**MEM_AW];

    logic              fault1;
    logic              fault2;
    logic              live1;
    logic              live2;
    logic              st1;
    logic              st2;
    logic [MEM_AW-1:0] idx1;
    logic [MEM_AW-1:0] idx2;
    logic [XLEN-1:0]   ld_data1;
    logic [XLEN-1:0]   ld_data2;
    wb_pkt_t           wb1_d;
    wb_pkt_t           wb2_d;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // alignment and kill
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // output reg is free when it holds no valid writeback
    assign mem_allowin_o = !(wb1_o.valid || wb2_o.valid) || wb_allowin_i;

    // only load/store can fault
    assign fault1 = lane1_valid_i && (mem_bus_i[0].op inside {OP_LOAD, OP_STORE})
                    && (mem_bus_i[0].result[1:0] != 2'b00);
    assign fault2 = lane2_valid_i && (mem_bus_i[1].op inside {OP_LOAD, OP_STORE})
                    && (mem_bus_i[1].result[1:0] != 2'b00);

    // flush only when the faulting packet actually leaves the stage
    assign excep_flush_o = mem_allowin_o && (fault1 || fault2);

    // lane 1 fault takes the younger lane with it
    assign live1 = lane1_valid_i && !fault1;
    assign live2 = lane2_valid_i && !fault1 && !fault2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory access
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // word index
    assign idx1 = mem_bus_i[0].result[MEM_AW+1:2];
    assign idx2 = mem_bus_i[1].result[MEM_AW+1:2];

    // write enables, gated by advance so a held packet writes once
    assign st1 = mem_allowin_o && live1 && (mem_bus_i[0].op == OP_STORE);
    assign st2 = mem_allowin_o && live2 && (mem_bus_i[1].op == OP_STORE);

    // lane 1 reads the old word
    assign ld_data1 = mem_q[idx1];
    // lane 2 sees an older lane 1 store to the same word
    assign ld_data2 = (st1 && (idx1 == idx2)) ? mem_bus_i[0].store_data : mem_q[idx2];

    // lane order, lane 2 written last so it wins on a shared word
    always_ff @(posedge clk) begin
        if (st1) begin
            mem_q[idx1] <= mem_bus_i[0].store_data;
        end
        if (st2) begin
            mem_q[idx2] <= mem_bus_i[1].store_data;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // writeback and exception registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // stores write back with valid low
    always_comb begin
        wb1_d.valid = live1 && (mem_bus_i[0].op != OP_STORE);
        wb1_d.rd    = mem_bus_i[0].rd;
        wb1_d.data  = (mem_bus_i[0].op == OP_LOAD) ? ld_data1 : mem_bus_i[0].result;
        wb2_d.valid = live2 && (mem_bus_i[1].op != OP_STORE);
        wb2_d.rd    = mem_bus_i[1].rd;
        wb2_d.data  = (mem_bus_i[1].op == OP_LOAD) ? ld_data2 : mem_bus_i[1].result;
    end

    // hold while the writeback side is stalled
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb1_o <= '0;
            wb2_o <= '0;
        end else if (mem_allowin_o) begin
            wb1_o <= wb1_d;
            wb2_o <= wb2_d;
        end
    end

    // one-cycle pulse, the flush empties the stage behind it
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            excp_o <= '0;
        end else begin
            excp_o.valid    <= excep_flush_o;
            excp_o.lane     <= !fault1;
            excp_o.bad_addr <= fault1 ? mem_bus_i[0].result : mem_bus_i[1].result;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/exmem_pkg.sv
source/ex_stage.sv
source/ex_mem_reg.sv
source/mem_stage.sv
source/exmem_top.sv
sim/exmem_props.sv
sim/exmem_tb.sv
